/* build.f */
+incdir+include
hdl/addrgen_pkg.sv
hdl/addr_loop_counter.sv
hdl/transfer_tracker.sv
hdl/addr_output_stage.sv
hdl/addrgen_top.sv
verification/addrgen_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the address generator testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f build.f \
  --top-module addrgen_tb -Mdir obj_dir -o addrgen_sim
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

out=$(./obj_dir/addrgen_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* verification/addrgen_cases.txt */
// case header: kind base trans_size line_stride line_length feat_stride feat_length feat_roll outer beats
// kind 0 = back to back beats, 1 = random stalls; beat line: address strobe flags{word,line,feat,in_progress}
// aligned single line, wraps to base after the last word
0 00001000 4 10 4 0 1 1 0 5
00001000 f 9
00001004 f 9
00001008 f 9
0000100c f f
00001000 f 8
// two lines of two words, two features with a negative feature stride
0 00002000 64 100 2 ffc0 2 2 0 9
00002000 f 9
00002004 f d
00002100 f 9
00002104 f f
00001fc0 f 9
00001fc4 f d
000020c0 f 9
000020c4 f f
00002000 f 9
// outer mode, feature offset moves only when the roll count wraps
0 00003000 64 20 2 100 1 2 1 6
00003000 f 9
00003004 f f
00003000 f 9
00003004 f f
00003100 f 9
00003104 f f
// misaligned base, three beats per line, first beat of each line not counted
0 00004001 4 10 2 0 2 1 0 7
00004000 e 9
00004004 f 9
00004008 1 d
00004010 e 9
00004014 f 9
00004018 1 f
00004000 e 8
// random stalls, stops in the middle of the second line
1 00005000 5 40 3 0 2 1 0 4
00005000 f 9
00005004 f 9
00005008 f d
00005040 f 9
// same control after a clear, restarts at base and runs to the end
0 00005000 5 40 3 0 2 1 0 6
00005000 f 9
00005004 f 9
00005008 f d
00005040 f 9
00005044 f 9
00005048 f e
ffffffff

/* verification/addrgen_tb.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the strided address generator, replays the case file
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "addrgen_defines.svh"

module addrgen_tb;

  localparam int          MEM_WORDS = 512;
  localparam logic [31:0] END_MARK  = 32'hffff_ffff;

  logic                        clk;
  logic                        rst_n;
  logic                        enable;
  logic                        clear;
  addrgen_pkg::addrgen_ctrl_t  ctrl;
  logic [31:0]                 gen_addr;
  logic [`ADDRGEN_STEP-1:0]    gen_strb;
  addrgen_pkg::addrgen_flags_t flags;

  logic [31:0] case_mem [0:MEM_WORDS-1];
  integer      seed;
  int          err_count   = 0;
  int          check_count = 0;
  int          wd_cycles   = 0;

  addrgen_top #(
    .DELAY_FLAGS (0)
  ) dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .enable_i   (enable),
    .clear_i    (clear),
    .ctrl_i     (ctrl),
    .gen_addr_o (gen_addr),
    .gen_strb_o (gen_strb),
    .flags_o    (flags)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // stops a hung run, limit set once the case file is scanned
  initial begin
    wait (wd_cycles != 0);
    repeat (wd_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", wd_cycles);
    $display(">>> FAIL");
    $finish;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    check_count = check_count + 1;
    assert (actual === expected) else begin
      $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, expected, actual);
      err_count = err_count + 1;
    end
  endtask

  // set when the base or a stride is not a whole number of words
  function automatic logic expect_misaligned(input addrgen_pkg::addrgen_ctrl_t c);
    return ((c.base_addr % 32'(`ADDRGEN_STEP)) != 32'd0) ||
           (({16'd0, c.line_stride} % 32'(`ADDRGEN_STEP)) != 32'd0) ||
           (({16'd0, c.feat_stride} % 32'(`ADDRGEN_STEP)) != 32'd0);
  endfunction

  // drive on the falling edge, leave time to settle before the rising edge
  task automatic drive_cycle(input logic en);
    @(negedge clk);
    enable = en;
    #15;
  endtask

  task automatic run_case(input int hdr, input int case_no);
    int   kind;
    int   nbeats;
    int   stalls;
    int   p;
    int   errs_before;
    logic exp_mis;
    kind        = int'(case_mem[hdr]);
    nbeats      = int'(case_mem[hdr+9]);
    errs_before = err_count;
    @(negedge clk);
    ctrl.base_addr   = case_mem[hdr+1];
    ctrl.trans_size  = case_mem[hdr+2];
    ctrl.line_stride = case_mem[hdr+3][15:0];
    ctrl.line_length = case_mem[hdr+4][15:0];
    ctrl.feat_stride = case_mem[hdr+5][15:0];
    ctrl.feat_length = case_mem[hdr+6][15:0];
    ctrl.feat_roll   = case_mem[hdr+7][15:0];
    ctrl.loop_outer  = case_mem[hdr+8][0];
    ctrl.pad         = '0;
    exp_mis          = expect_misaligned(ctrl);
    clear = 1'b1;
    @(negedge clk);
    clear = 1'b0;
    @(negedge clk);  // misaligned bit settles
    for (int b = 0; b < nbeats; b++) begin
      p = hdr + 10 + 3 * b;
      if (kind == 1) begin
        stalls = $unsigned($random(seed)) % 3;
        repeat (stalls) begin
          drive_cycle(1'b0);
          compare_value("update flags",
                        32'h0,
                        32'({flags.word_update, flags.line_update, flags.feat_update}));
        end
      end
      drive_cycle(1'b1);
      compare_value("gen_addr_o", case_mem[p], gen_addr);
      compare_value("gen_strb_o", case_mem[p+1], 32'(gen_strb));
      compare_value("flags_o", case_mem[p+2],
                    32'({flags.word_update, flags.line_update,
                         flags.feat_update, flags.in_progress}));
      compare_value("flags_o.misaligned", 32'(exp_mis), 32'(flags.misaligned));
    end
    @(negedge clk);
    enable = 1'b0;
    $display("case %0d, %0d beats: %s", case_no, nbeats,
             (err_count == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin
    int ptr;
    int total;
    int case_no;
    seed   = 32'h6a04;
    rst_n  = 1'b0;
    enable = 1'b0;
    clear  = 1'b0;
    ctrl   = '0;
    $readmemh("verification/addrgen_cases.txt", case_mem);
    ptr   = 0;
    total = 0;
    while ((ptr < MEM_WORDS - 10) && (case_mem[ptr] !== END_MARK) &&
           !$isunknown(case_mem[ptr])) begin
      total = total + int'(case_mem[ptr+9]);
      ptr   = ptr + 10 + 3 * int'(case_mem[ptr+9]);
    end
    wd_cycles = total * 4 + 200;
    repeat (10) @(negedge clk);
    rst_n   = 1'b1;
    case_no = 0;
    if (case_mem[ptr] !== END_MARK) begin
      $display("case file is missing or has a broken layout");
      err_count = err_count + 1;
    end else begin
      ptr = 0;
      while (case_mem[ptr] !== END_MARK) begin
        case_no = case_no + 1;
        run_case(ptr, case_no);
        ptr = ptr + 10 + 3 * int'(case_mem[ptr+9]);
      end
    end
    $display("cases %0d, checks %0d, errors %0d", case_no, check_count, err_count);
    if (err_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/addrgen_top.sv */
////////////////////////////////////////////////////////////////////////////
// strided address generator for a 32-bit streaming memory port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "addrgen_defines.svh"

module addrgen_top #(
  parameter int unsigned DELAY_FLAGS = `ADDRGEN_DELAY_FLAGS
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        enable_i,  // one beat per high cycle
  input  logic                        clear_i,
  input  addrgen_pkg::addrgen_ctrl_t  ctrl_i,
  output logic [31:0]                 gen_addr_o,
  output logic [`ADDRGEN_STEP-1:0]    gen_strb_o,
  output addrgen_pkg::addrgen_flags_t flags_o
);

  addrgen_pkg::loop_pos_t pos;   // current beat position
  addrgen_pkg::progress_t prog;

  addr_loop_counter u_loop_counter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .enable_i     (enable_i),
    .clear_i      (clear_i),
    .ctrl_i       (ctrl_i),
    .misaligned_i (prog.misaligned),
    .pos_o        (pos)
  );

  transfer_tracker u_transfer_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .enable_i     (enable_i),
    .clear_i      (clear_i),
    .ctrl_i       (ctrl_i),
    .line_first_i (pos.first),
    .prog_o       (prog)
  );

  addr_output_stage #(
    .DELAY_FLAGS (DELAY_FLAGS)
  ) u_output_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .enable_i    (enable_i),
    .base_addr_i (ctrl_i.base_addr),
    .pos_i       (pos),
    .prog_i      (prog),
    .gen_addr_o  (gen_addr_o),
    .gen_strb_o  (gen_strb_o),
    .flags_o     (flags_o)
  );

endmodule

`default_nettype wire

/* hdl/addr_output_stage.sv */
////////////////////////////////////////////////////////////////////////////
// strided address generator, address sum and alignment, byte strobes,
// update flags and an optional one-cycle output register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "addrgen_defines.svh"

module addr_output_stage #(
  parameter int unsigned DELAY_FLAGS = `ADDRGEN_DELAY_FLAGS
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        clear_i,
  input  logic                        enable_i,
  input  logic [31:0]                 base_addr_i,
  input  addrgen_pkg::loop_pos_t      pos_i,
  input  addrgen_pkg::progress_t      prog_i,
  output logic [31:0]                 gen_addr_o,
  output logic [`ADDRGEN_STEP-1:0]    gen_strb_o,
  output addrgen_pkg::addrgen_flags_t flags_o
);

  localparam int unsigned LSB_W = $clog2(`ADDRGEN_STEP);

  logic [31:0]                 addr_sum;
  logic [31:0]                 addr_int;
  logic [`ADDRGEN_STEP-1:0]    strb_head;
  logic [`ADDRGEN_STEP-1:0]    strb_int;
  addrgen_pkg::addrgen_flags_t flags_int;

  assign addr_sum  = base_addr_i + pos_i.feat_off + pos_i.line_off + pos_i.word_off;
  assign addr_int  = {addr_sum[31:LSB_W], {LSB_W{1'b0}}};
  // lanes from the start byte up
  assign strb_head = {`ADDRGEN_STEP{1'b1}} << addr_sum[LSB_W-1:0];

  always_comb begin
    strb_int = '1;
    if (prog_i.misaligned) begin
      if (pos_i.first) begin
        strb_int = strb_head;
      end
      if (pos_i.last) begin
        strb_int = ~strb_head;  // tail lanes of the extra beat
      end
    end
  end

  always_comb begin
    flags_int             = '0;
    flags_int.in_progress = prog_i.in_progress;
    flags_int.misaligned  = prog_i.misaligned;
    if (enable_i) begin
      case (pos_i.step)
        addrgen_pkg::STEP_WORD: begin
          flags_int.word_update = 1'b1;
        end
        addrgen_pkg::STEP_LINE: begin
          flags_int.word_update = 1'b1;
          flags_int.line_update = 1'b1;
        end
        addrgen_pkg::STEP_FEAT, addrgen_pkg::STEP_WRAP: begin
          flags_int.word_update = 1'b1;
          flags_int.line_update = 1'b1;
          flags_int.feat_update = 1'b1;
        end
        default: ;
      endcase
    end
  end

  if (DELAY_FLAGS != 0) begin : g_delay
    // idle value, transfer pending but nothing updated
    localparam addrgen_pkg::addrgen_flags_t FLAGS_IDLE = '{
      word_update: 1'b0, line_update: 1'b0, feat_update: 1'b0,
      in_progress: 1'b1, misaligned: 1'b0
    };

    logic [31:0]                 addr_q;
    logic [`ADDRGEN_STEP-1:0]    strb_q;
    addrgen_pkg::addrgen_flags_t flags_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        addr_q  <= '0;
        strb_q  <= '0;
        flags_q <= FLAGS_IDLE;
      end else if (clear_i) begin
        addr_q  <= '0;
        strb_q  <= '0;
        flags_q <= FLAGS_IDLE;
      end else begin
        addr_q  <= addr_int;
        strb_q  <= strb_int;
        flags_q <= flags_int;
      end
    end

    assign gen_addr_o = addr_q;
    assign gen_strb_o = strb_q;
    assign flags_o    = flags_q;
  end else begin : g_direct
    assign gen_addr_o = addr_int;
    assign gen_strb_o = strb_int;
    assign flags_o    = flags_int;
  end

endmodule

`default_nettype wire

/* hdl/transfer_tracker.sv */
////////////////////////////////////////////////////////////////////////////
// strided address generator, misalignment detection and transfer
// progress based on a count of the beats that carry data
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "addrgen_defines.svh"

module transfer_tracker (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       enable_i,
  input  logic                       clear_i,
  input  addrgen_pkg::addrgen_ctrl_t ctrl_i,
  input  logic                       line_first_i,
  output addrgen_pkg::progress_t     prog_o
);

  localparam int unsigned LSB_W = $clog2(`ADDRGEN_STEP);

  logic        misaligned_q;
  logic        in_progress_q;
  logic [15:0] beat_cnt;
  logic [15:0] beat_cnt_nxt;
  logic        counted;

  // first beat of a misaligned line only primes the realigner
  assign counted      = enable_i && !(misaligned_q && line_first_i);
  assign beat_cnt_nxt = beat_cnt + 16'd1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      misaligned_q <= 1'b0;
    end else begin
      misaligned_q <= (ctrl_i.base_addr[LSB_W-1:0] != '0) ||
                      (ctrl_i.line_stride[LSB_W-1:0] != '0) ||
                      (ctrl_i.feat_stride[LSB_W-1:0] != '0);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt      <= '0;
      in_progress_q <= 1'b1;
    end else if (clear_i) begin
      beat_cnt      <= '0;
      in_progress_q <= 1'b1;
    end else begin
      if (counted) begin
        beat_cnt <= beat_cnt_nxt;
      end
      if (ctrl_i.trans_size == 32'd1) begin
        in_progress_q <= 1'b0;  // single beat transfer
      end else if (counted && ({16'd0, beat_cnt_nxt} == ctrl_i.trans_size)) begin
        in_progress_q <= 1'b0;
      end
    end
  end

  assign prog_o.misaligned  = misaligned_q;
  assign prog_o.in_progress = in_progress_q;

endmodule

`default_nettype wire

/* hdl/addr_loop_counter.sv */
////////////////////////////////////////////////////////////////////////////
// strided address generator, three nested loop counters (word, line,
// feature) with their byte offsets and line position flags
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "addrgen_defines.svh"

module addr_loop_counter (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       enable_i,
  input  logic                       clear_i,
  input  addrgen_pkg::addrgen_ctrl_t ctrl_i,
  input  logic                       misaligned_i,
  output addrgen_pkg::loop_pos_t     pos_o
);

  logic [`ADDRGEN_CNT_W-1:0] word_cnt;
  logic [`ADDRGEN_CNT_W-1:0] line_cnt;
  logic [`ADDRGEN_CNT_W-1:0] feat_cnt;
  logic [31:0]               word_off;
  logic [31:0]               line_off;
  logic [31:0]               feat_off;
  logic [31:0]               line_step;
  logic [31:0]               feat_step;
  logic [15:0]               line_len_m1;
  logic [15:0]               feat_len_m1;
  logic [15:0]               feat_roll_m1;
  logic                      roll_done;
  addrgen_pkg::loop_step_e   step;

  // a misaligned line needs one extra beat
  assign line_len_m1  = misaligned_i ? ctrl_i.line_length : ctrl_i.line_length - 16'd1;
  assign feat_len_m1  = ctrl_i.feat_length - 16'd1;
  assign feat_roll_m1 = ctrl_i.feat_roll - 16'd1;

  assign line_step = {{16{ctrl_i.line_stride[15]}}, ctrl_i.line_stride};
  assign feat_step = {{16{ctrl_i.feat_stride[15]}}, ctrl_i.feat_stride};

  // outer mode moves the feature offset only when the roll count wraps
  assign roll_done = (16'(feat_cnt) == feat_roll_m1) || (ctrl_i.feat_roll == '0);

  always_comb begin
    if (!enable_i) begin
      step = addrgen_pkg::STEP_NONE;
    end else if (16'(word_cnt) < line_len_m1) begin
      step = addrgen_pkg::STEP_WORD;
    end else if (16'(line_cnt) < feat_len_m1) begin
      step = addrgen_pkg::STEP_LINE;
    end else if (ctrl_i.loop_outer || (16'(feat_cnt) < feat_roll_m1)) begin
      step = addrgen_pkg::STEP_FEAT;
    end else begin
      step = addrgen_pkg::STEP_WRAP;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_cnt <= '0;
      line_cnt <= '0;
      feat_cnt <= '0;
      word_off <= '0;
      line_off <= '0;
      feat_off <= '0;
    end else if (clear_i || (step == addrgen_pkg::STEP_WRAP)) begin
      word_cnt <= '0;
      line_cnt <= '0;
      feat_cnt <= '0;
      word_off <= '0;
      line_off <= '0;
      feat_off <= '0;
    end else begin
      case (step)
        addrgen_pkg::STEP_WORD: begin
          word_off <= word_off + 32'(`ADDRGEN_STEP);
          word_cnt <= word_cnt + 1'b1;
        end
        addrgen_pkg::STEP_LINE: begin
          word_off <= '0;
          word_cnt <= '0;
          line_off <= line_off + line_step;
          line_cnt <= line_cnt + 1'b1;
        end
        addrgen_pkg::STEP_FEAT: begin
          word_off <= '0;
          word_cnt <= '0;
          line_off <= '0;
          line_cnt <= '0;
          if (!ctrl_i.loop_outer) begin
            feat_off <= feat_off + feat_step;
            feat_cnt <= feat_cnt + 1'b1;
          end else if (roll_done) begin
            feat_off <= feat_off + feat_step;
            feat_cnt <= '0;
          end else begin
            feat_cnt <= feat_cnt + 1'b1;  // same feature, next roll
          end
        end
        default: ;  // stall, hold everything
      endcase
    end
  end

  assign pos_o.word_off = word_off;
  assign pos_o.line_off = line_off;
  assign pos_o.feat_off = feat_off;
  assign pos_o.first    = (word_cnt == '0);
  assign pos_o.last     = !(16'(word_cnt) < line_len_m1);
  assign pos_o.step     = step;

endmodule

`default_nettype wire

/* hdl/addrgen_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// strided address generator, shared types for control, loop position,
// transfer progress and output flags
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package addrgen_pkg;

  // loop level advanced by a beat
  typedef enum logic [2:0] {
    STEP_NONE = 3'd0,  // no beat this cycle
    STEP_WORD = 3'd1,
    STEP_LINE = 3'd2,
    STEP_FEAT = 3'd3,
    STEP_WRAP = 3'd4   // whole loop nest restarts at base
  } loop_step_e;

  // held stable for the length of a transfer
  typedef struct packed {
    logic        [31:0] base_addr;
    logic        [31:0] trans_size;   // counted beats
    logic signed [15:0] line_stride;  // bytes between lines
    logic        [15:0] line_length;  // words per line
    logic signed [15:0] feat_stride;
    logic        [15:0] feat_length;  // lines per feature
    logic        [15:0] feat_roll;
    logic               loop_outer;
    logic        [6:0]  pad;
  } addrgen_ctrl_t;

  typedef struct packed {
    logic [31:0] word_off;
    logic [31:0] line_off;
    logic [31:0] feat_off;
    logic        first;  // word index is zero
    logic        last;   // final beat of the line
    loop_step_e  step;
  } loop_pos_t;

  typedef struct packed {
    logic misaligned;
    logic in_progress;
  } progress_t;

  typedef struct packed {
    logic word_update;
    logic line_update;
    logic feat_update;
    logic in_progress;
    logic misaligned;
  } addrgen_flags_t;

endpackage

`default_nettype wire

/* include/addrgen_defines.svh */
////////////////////////////////////////////////////////////////////////////
// strided address generator, shared sizing constants
////////////////////////////////////////////////////////////////////////////

`ifndef ADDRGEN_DEFINES_SVH
`define ADDRGEN_DEFINES_SVH

// bytes per bus word, four byte lanes
`define ADDRGEN_STEP 4

// width of the word, line and feature index counters
`define ADDRGEN_CNT_W 10

// default output timing, 0 = combinational, 1 = one cycle later
`define ADDRGEN_DELAY_FLAGS 0

`endif
